/* project.f */
+incdir+dv
logic/core_pkg.sv
logic/regfile.sv
logic/decoder.sv
logic/ex_stage.sv
logic/commit_stage.sv
logic/mini_core.sv
dv/core_tb.sv

/* Bender.yml */
package:
  name: mini_core

sources:
  - logic/core_pkg.sv
  - logic/regfile.sv
  - logic/decoder.sv
  - logic/ex_stage.sv
  - logic/commit_stage.sv
  - logic/mini_core.sv

  - target: test
    include_dirs:
      - dv
    files:
      - dv/core_tb.sv

/* dv/core_model.svh */
`ifndef CORE_MODEL_SVH
`define CORE_MODEL_SVH

// ----------------------------------------
// reference model of the RV32I subset
// ----------------------------------------
typedef struct {
  core_pkg::commit_record_t rec;
  int unsigned              due;
} expected_t;

logic [31:0] model_regs [32];
expected_t   exp_q [$];

task automatic model_reset();
  for (int i = 0; i < 32; i++) begin
    model_regs[i] = '0;
  end
  exp_q.delete();
endtask

// two's complement compare from the sign bits
function automatic logic less_signed(input logic [31:0] a, input logic [31:0] b);
  if (a[31] != b[31]) begin
    return a[31];
  end
  return a < b;
endfunction

function automatic logic [31:0] shift_right_arith(input logic [31:0] a, input logic [4:0] sh);
  logic [31:0] fill;
  fill = a[31] ? ~(32'hffff_ffff >> sh) : 32'h0;
  return (a >> sh) | fill;
endfunction

// alt selects sub or sra
function automatic logic [31:0] alu_eval(input logic [2:0] f3, input logic alt,
                                         input logic [31:0] a, input logic [31:0] b);
  case (f3)
    3'b000:  return alt ? a - b : a + b;
    3'b001:  return a << b[4:0];
    3'b010:  return {31'b0, less_signed(a, b)};
    3'b011:  return {31'b0, a < b};
    3'b100:  return a ^ b;
    3'b101:  return alt ? shift_right_arith(a, b[4:0]) : a >> b[4:0];
    3'b110:  return a | b;
    default: return a & b;
  endcase
endfunction

task automatic model_step(input logic [31:0] pc, input logic [31:0] instr,
                          input int unsigned due);
  expected_t   entry;
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] imm_i;
  logic [31:0] res;
  logic [2:0]  f3;
  logic [6:0]  f7;
  logic        wr;
  logic        illegal;
  f3        = instr[14:12];
  f7        = instr[31:25];
  a         = model_regs[instr[19:15]];
  b         = model_regs[instr[24:20]];
  imm_i     = {{20{instr[31]}}, instr[31:20]};
  entry.rec = '0;
  entry.due = due;
  entry.rec.pc    = pc;
  entry.rec.instr = instr;
  entry.rec.rd    = instr[11:7];
  wr        = 1'b0;
  illegal   = 1'b0;
  res       = '0;
  case (instr[6:0])
    7'b0110011: begin
      wr      = 1'b1;
      illegal = (f7 != 7'b0000000) &&
                !((f7 == 7'b0100000) && ((f3 == 3'b000) || (f3 == 3'b101)));
      res     = alu_eval(f3, f7[5], a, b);
    end
    7'b0010011: begin
      wr = 1'b1;
      if (f3 == 3'b001) begin
        illegal = (f7 != 7'b0000000);
      end
      if (f3 == 3'b101) begin
        illegal = (f7 != 7'b0000000) && (f7 != 7'b0100000);
      end
      res = alu_eval(f3, (f3 == 3'b101) && f7[5], a, imm_i);
    end
    7'b0110111: begin
      wr  = 1'b1;
      res = {instr[31:12], 12'b0};
    end
    7'b0010111: begin
      wr  = 1'b1;
      res = pc + {instr[31:12], 12'b0};
    end
    7'b1101111: begin
      wr  = 1'b1;
      res = pc + 32'd4;
      entry.rec.taken  = 1'b1;
      entry.rec.target = pc + {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
    end
    7'b1100111: begin
      wr      = 1'b1;
      illegal = (f3 != 3'b000);
      res     = pc + 32'd4;
      entry.rec.taken  = 1'b1;
      entry.rec.target = (a + imm_i) & 32'hffff_fffe;
    end
    7'b1100011: begin
      entry.rec.target = pc + {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
      case (f3)
        3'b000:  entry.rec.taken = (a == b);
        3'b001:  entry.rec.taken = (a != b);
        3'b100:  entry.rec.taken = less_signed(a, b);
        3'b101:  entry.rec.taken = !less_signed(a, b);
        3'b110:  entry.rec.taken = (a < b);
        3'b111:  entry.rec.taken = !(a < b);
        default: illegal = 1'b1;
      endcase
    end
    default: illegal = 1'b1;
  endcase

  if (illegal) begin
    entry.rec.taken    = 1'b0;
    entry.rec.target   = '0;
    entry.rec.ex_valid = 1'b1;
    entry.rec.cause    = 32'd2;
  end else if (wr && (instr[11:7] != 5'd0)) begin
    entry.rec.we          = 1'b1;
    entry.rec.wdata       = res;
    model_regs[instr[11:7]] = res;
  end
  exp_q.push_back(entry);
endtask

`endif

/* dv/core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module core_tb;

  localparam int unsigned NUM_INSTR      = 2000;
  localparam int unsigned TIMEOUT_CYCLES = NUM_INSTR * 2 + 100;
  localparam int unsigned DRIVE_DELAY    = 1;

  logic                           clk_i;
  logic                           rst_ni;
  logic                           instr_valid_i;
  logic [31:0]                    instr_i;
  logic [31:0]                    pc_i;
  logic                           commit_valid_o;
  core_pkg::commit_record_t       commit_o;
  logic [core_pkg::INSTRET_W-1:0] instret_o;

  int unsigned cycle;
  int unsigned sent;
  int unsigned retired;
  int unsigned run_cycles;

  `include "core_model.svh"

  mini_core dut_i (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .instr_valid_i  ( instr_valid_i  ),
    .instr_i        ( instr_i        ),
    .pc_i           ( pc_i           ),
    .commit_valid_o ( commit_valid_o ),
    .commit_o       ( commit_o       ),
    .instret_o      ( instret_o      )
  );

  // 8 ns period
  always #4 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    if (rst_ni) begin
      run_cycles++;
      if (run_cycles > TIMEOUT_CYCLES) begin
        $display("error: run timed out after %0d cycles, %0d records still pending",
                 run_cycles, exp_q.size());
        $display("STATUS: FAIL");
        $fatal(1, "timeout");
      end
    end
  end

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("[FAIL] %s: got 0x%08h, expected 0x%08h", name, actual, expected);
      $display("STATUS: FAIL");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  // ----------------------------------------
  // stimulus
  // ----------------------------------------
  // few registers so dependencies are frequent
  function automatic logic [4:0] pick_reg();
    return 5'($urandom_range(0, 5));
  endfunction

  function automatic logic [31:0] random_instr();
    logic [31:0] r;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [6:0]  f7;
    int unsigned kind;
    r    = $urandom;
    rd   = pick_reg();
    rs1  = pick_reg();
    rs2  = pick_reg();
    f3   = r[14:12];
    kind = $urandom_range(0, 99);
    if (kind < 5) begin
      // load, system, mul, bad branch funct3
      case ($urandom_range(0, 3))
        0:       return {r[31:7], 7'b0000011};
        1:       return {r[31:7], 7'b1110011};
        2:       return {7'b0000001, rs2, rs1, f3, rd, 7'b0110011};
        default: return {r[31:15], 3'b010, r[11:7], 7'b1100011};
      endcase
    end else if (kind < 35) begin
      f7 = (((f3 == 3'b000) || (f3 == 3'b101)) && r[30]) ? 7'b0100000 : 7'b0000000;
      return {f7, rs2, rs1, f3, rd, 7'b0110011};
    end else if (kind < 60) begin
      f7 = r[31:25];
      if (f3 == 3'b001) begin
        f7 = 7'b0000000;
      end else if (f3 == 3'b101) begin
        f7 = r[30] ? 7'b0100000 : 7'b0000000;
      end
      return {f7, r[24:20], rs1, f3, rd, 7'b0010011};
    end else if (kind < 68) begin
      return {r[31:12], rd, 7'b0110111};
    end else if (kind < 76) begin
      return {r[31:12], rd, 7'b0010111};
    end else if (kind < 84) begin
      return {r[31:12], rd, 7'b1101111};
    end else if (kind < 90) begin
      return {r[31:20], rs1, 3'b000, rd, 7'b1100111};
    end
    case ($urandom_range(0, 5))
      0:       f3 = 3'b000;
      1:       f3 = 3'b001;
      2:       f3 = 3'b100;
      3:       f3 = 3'b101;
      4:       f3 = 3'b110;
      default: f3 = 3'b111;
    endcase
    return {r[31:25], rs2, rs1, f3, r[11:7], 7'b1100011};
  endfunction

  task automatic drive_next();
    logic [31:0] pc;
    logic [31:0] instr;
    pc    = $urandom & 32'hffff_fffc;
    instr = random_instr();
    pc_i  = pc;
    if ($urandom_range(0, 3) != 0) begin
      instr_valid_i = 1'b1;
      instr_i       = instr;
      // visible after the third edge from here
      model_step(pc, instr, cycle + 3);
      sent++;
    end else begin
      instr_valid_i = 1'b0;
      instr_i       = $urandom;
    end
  endtask

  // ----------------------------------------
  // checking
  // ----------------------------------------
  task automatic check_outputs();
    expected_t entry;
    if ((exp_q.size() != 0) && (exp_q[0].due == cycle)) begin
      entry = exp_q.pop_front();
      check_value("commit_valid_o", commit_valid_o, 32'd1);
      check_value("commit_o.pc", commit_o.pc, entry.rec.pc);
      check_value("commit_o.instr", commit_o.instr, entry.rec.instr);
      check_value("commit_o.rd", commit_o.rd, entry.rec.rd);
      check_value("commit_o.we", commit_o.we, entry.rec.we);
      check_value("commit_o.wdata", commit_o.wdata, entry.rec.wdata);
      check_value("commit_o.taken", commit_o.taken, entry.rec.taken);
      check_value("commit_o.target", commit_o.target, entry.rec.target);
      check_value("commit_o.ex_valid", commit_o.ex_valid, entry.rec.ex_valid);
      check_value("commit_o.cause", commit_o.cause, entry.rec.cause);
      if (!entry.rec.ex_valid) begin
        retired++;
      end
    end else begin
      check_value("commit_valid_o", commit_valid_o, 32'd0);
    end
    check_value("instret_o", instret_o, retired);
  endtask

  task automatic step_cycle();
    @(posedge clk_i);
    #DRIVE_DELAY;
    cycle++;
    check_outputs();
  endtask

  initial begin
    void'($urandom(32'hbc6edf95));
    clk_i         = 1'b0;
    rst_ni        = 1'b0;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    pc_i          = '0;
    cycle         = 0;
    sent          = 0;
    retired       = 0;
    run_cycles    = 0;
    model_reset();

    repeat (4) @(posedge clk_i);
    #DRIVE_DELAY;
    rst_ni = 1'b1;
    // idle core straight out of reset
    check_value("commit_valid_o", commit_valid_o, 32'd0);
    check_value("instret_o", instret_o, 32'd0);

    while (sent < NUM_INSTR) begin
      drive_next();
      step_cycle();
    end
    instr_valid_i = 1'b0;
    repeat (4) step_cycle();

    if (exp_q.size() == 0) begin
      $display("STATUS: PASS");
      $finish;
    end else begin
      $display("error: %0d expected records were never committed", exp_q.size());
      $display("STATUS: FAIL");
      $fatal(1, "records missing");
    end
  end

endmodule

`default_nettype wire

/* logic/mini_core.sv */
`timescale 1ns/1ps
`default_nettype none

module mini_core (
  input  wire logic                              clk_i,
  input  wire logic                              rst_ni,
  input  wire logic                              instr_valid_i,
  input  wire logic [core_pkg::XLEN-1:0]         instr_i,
  input  wire logic [core_pkg::XLEN-1:0]         pc_i,
  output logic                                   commit_valid_o,
  output core_pkg::commit_record_t               commit_o,
  output logic [core_pkg::INSTRET_W-1:0]         instret_o
);

  // ----------------------------------------
  // stage to stage
  // ----------------------------------------
  core_pkg::decoded_instr_t              decoded_id_ex;
  core_pkg::exec_result_t                result_ex_commit;
  core_pkg::reg_write_t                  write_commit_rf;
  logic [core_pkg::REG_ADDR_W-1:0]       rs1_addr_ex_rf, rs2_addr_ex_rf;
  logic [core_pkg::XLEN-1:0]             rs1_data_rf_ex, rs2_data_rf_ex;

  decoder decoder_i (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .instr_valid_i ( instr_valid_i ),
    .instr_i       ( instr_i       ),
    .pc_i          ( pc_i          ),
    .decoded_o     ( decoded_id_ex )
  );

  ex_stage ex_stage_i (
    .clk_i      ( clk_i            ),
    .rst_ni     ( rst_ni           ),
    .decoded_i  ( decoded_id_ex    ),
    .rs1_addr_o ( rs1_addr_ex_rf   ),
    .rs2_addr_o ( rs2_addr_ex_rf   ),
    .rs1_data_i ( rs1_data_rf_ex   ),
    .rs2_data_i ( rs2_data_rf_ex   ),
    .result_o   ( result_ex_commit )
  );

  commit_stage commit_stage_i (
    .clk_i          ( clk_i            ),
    .rst_ni         ( rst_ni           ),
    .result_i       ( result_ex_commit ),
    .reg_write_o    ( write_commit_rf  ),
    .commit_valid_o ( commit_valid_o   ),
    .commit_o       ( commit_o         ),
    .instret_o      ( instret_o        )
  );

  regfile regfile_i (
    .clk_i      ( clk_i           ),
    .rst_ni     ( rst_ni          ),
    .rs1_addr_i ( rs1_addr_ex_rf  ),
    .rs2_addr_i ( rs2_addr_ex_rf  ),
    .rs1_data_o ( rs1_data_rf_ex  ),
    .rs2_data_o ( rs2_data_rf_ex  ),
    .write_i    ( write_commit_rf )
  );

endmodule

`default_nettype wire

/* logic/commit_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module commit_stage (
  input  wire logic                              clk_i,
  input  wire logic                              rst_ni,
  input  core_pkg::exec_result_t                 result_i,
  output core_pkg::reg_write_t                   reg_write_o,
  output logic                                   commit_valid_o,
  output core_pkg::commit_record_t               commit_o,
  output logic [core_pkg::INSTRET_W-1:0]         instret_o
);

  logic                     wr_en;
  logic                     retire;
  core_pkg::commit_record_t rec_d, rec_q;
  logic                     valid_q;
  logic [core_pkg::INSTRET_W-1:0] instret_q;

  // ----------------------------------------
  // write-back
  // ----------------------------------------
  // x0 writes are dropped here
  assign wr_en  = result_i.valid && !result_i.illegal && result_i.we && (result_i.rd != '0);
  assign retire = result_i.valid && !result_i.illegal;

  assign reg_write_o.en   = wr_en;
  assign reg_write_o.addr = result_i.rd;
  assign reg_write_o.data = result_i.result;

  // ----------------------------------------
  // commit record
  // ----------------------------------------
  always_comb begin
    rec_d          = '0;
    rec_d.pc       = result_i.pc;
    rec_d.instr    = result_i.instr;
    rec_d.rd       = result_i.rd;
    rec_d.we       = wr_en;
    rec_d.wdata    = wr_en ? result_i.result : '0;
    rec_d.taken    = result_i.taken;
    rec_d.target   = result_i.target;
    rec_d.ex_valid = result_i.illegal;
    // tval is the instruction itself, already in the record
    rec_d.cause    = result_i.illegal ? core_pkg::ILLEGAL_INSTR_CAUSE : '0;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q   <= 1'b0;
      instret_q <= '0;
    end else begin
      valid_q <= result_i.valid;
      if (retire) begin
        instret_q <= instret_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    rec_q <= rec_d;
  end

  assign commit_valid_o = valid_q;
  assign commit_o       = rec_q;
  assign instret_o      = instret_q;

endmodule

`default_nettype wire

/* logic/ex_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_stage (
  input  wire logic                            clk_i,
  input  wire logic                            rst_ni,
  input  core_pkg::decoded_instr_t             decoded_i,
  output logic [core_pkg::REG_ADDR_W-1:0]      rs1_addr_o,
  output logic [core_pkg::REG_ADDR_W-1:0]      rs2_addr_o,
  input  wire logic [core_pkg::XLEN-1:0]       rs1_data_i,
  input  wire logic [core_pkg::XLEN-1:0]       rs2_data_i,
  output core_pkg::exec_result_t               result_o
);

  logic                       fwd_rs1, fwd_rs2;
  logic [core_pkg::XLEN-1:0]  rs1_val, rs2_val;
  logic [core_pkg::XLEN-1:0]  op_a, op_b;
  logic [core_pkg::XLEN-1:0]  alu_res;
  logic                       cmp_res;

  core_pkg::exec_result_t     res_d, res_q;
  logic                       valid_q;

  assign rs1_addr_o = decoded_i.rs1;
  assign rs2_addr_o = decoded_i.rs2;

  // ----------------------------------------
  // operand forwarding
  // ----------------------------------------
  // previous instruction is still in res_q, older ones are in the regfile
  assign fwd_rs1 = valid_q && res_q.we && (res_q.rd != '0) && (res_q.rd == decoded_i.rs1);
  assign fwd_rs2 = valid_q && res_q.we && (res_q.rd != '0) && (res_q.rd == decoded_i.rs2);

  assign rs1_val = fwd_rs1 ? res_q.result : rs1_data_i;
  assign rs2_val = fwd_rs2 ? res_q.result : rs2_data_i;

  assign op_a = decoded_i.use_pc  ? decoded_i.pc  : rs1_val;
  assign op_b = decoded_i.use_imm ? decoded_i.imm : rs2_val;

  // ----------------------------------------
  // ALU and branch compare
  // ----------------------------------------
  always_comb begin
    alu_res = '0;
    cmp_res = 1'b0;
    case (decoded_i.alu_op)
      core_pkg::ALU_ADD:  alu_res = op_a + op_b;
      core_pkg::ALU_SUB:  alu_res = op_a - op_b;
      core_pkg::ALU_AND:  alu_res = op_a & op_b;
      core_pkg::ALU_OR:   alu_res = op_a | op_b;
      core_pkg::ALU_XOR:  alu_res = op_a ^ op_b;
      core_pkg::ALU_SLT:  alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
      core_pkg::ALU_SLTU: alu_res = {31'b0, op_a < op_b};
      core_pkg::ALU_SLL:  alu_res = op_a << op_b[4:0];
      core_pkg::ALU_SRL:  alu_res = op_a >> op_b[4:0];
      core_pkg::ALU_SRA:  alu_res = $unsigned($signed(op_a) >>> op_b[4:0]);
      core_pkg::ALU_EQ:   cmp_res = (op_a == op_b);
      core_pkg::ALU_NE:   cmp_res = (op_a != op_b);
      core_pkg::ALU_LT:   cmp_res = $signed(op_a) < $signed(op_b);
      core_pkg::ALU_GE:   cmp_res = $signed(op_a) >= $signed(op_b);
      core_pkg::ALU_LTU:  cmp_res = op_a < op_b;
      default:            cmp_res = op_a >= op_b;
    endcase
  end

  always_comb begin
    res_d         = '0;
    res_d.valid   = decoded_i.valid;
    res_d.pc      = decoded_i.pc;
    res_d.instr   = decoded_i.instr;
    res_d.rd      = decoded_i.rd;
    res_d.illegal = decoded_i.illegal;

    if (!decoded_i.illegal) begin
      res_d.we = decoded_i.we;
      if (decoded_i.is_jal || decoded_i.is_jalr) begin
        // link value, jumps are always taken
        res_d.result = decoded_i.pc + 32'd4;
        res_d.taken  = 1'b1;
        if (decoded_i.is_jalr) begin
          res_d.target = (rs1_val + decoded_i.imm) & ~32'd1;
        end else begin
          res_d.target = decoded_i.pc + decoded_i.imm;
        end
      end else if (decoded_i.is_branch) begin
        res_d.taken  = cmp_res;
        res_d.target = decoded_i.pc + decoded_i.imm;
      end else begin
        res_d.result = alu_res;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= decoded_i.valid;
    end
  end

  always_ff @(posedge clk_i) begin
    res_q <= res_d;
  end

  always_comb begin
    result_o       = res_q;
    result_o.valid = valid_q;
  end

endmodule

`default_nettype wire

/* logic/decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module decoder (
  input  wire logic                           clk_i,
  input  wire logic                           rst_ni,
  input  wire logic                           instr_valid_i,
  input  wire logic [31:0]                    instr_i,
  input  wire logic [core_pkg::XLEN-1:0]      pc_i,
  output core_pkg::decoded_instr_t            decoded_o
);

  core_pkg::opcode_e        opcode;
  logic [2:0]               funct3;
  logic [6:0]               funct7;
  logic [core_pkg::XLEN-1:0] imm_i, imm_u, imm_j, imm_b;

  core_pkg::decoded_instr_t dec_d, dec_q;
  logic                     valid_q;

  assign opcode = core_pkg::opcode_e'(instr_i[6:0]);
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  // ----------------------------------------
  // immediates
  // ----------------------------------------
  assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_u = {instr_i[31:12], 12'b0};
  assign imm_j = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};
  assign imm_b = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};

  always_comb begin
    dec_d        = '0;
    dec_d.valid  = instr_valid_i;
    dec_d.pc     = pc_i;
    dec_d.instr  = instr_i;
    dec_d.alu_op = core_pkg::ALU_ADD;
    dec_d.rs1    = instr_i[19:15];
    dec_d.rs2    = instr_i[24:20];
    dec_d.rd     = instr_i[11:7];

    case (opcode)
      core_pkg::OPC_OP: begin
        dec_d.we = 1'b1;
        case (funct3)
          3'b000: dec_d.alu_op = funct7[5] ? core_pkg::ALU_SUB : core_pkg::ALU_ADD;
          3'b001: dec_d.alu_op = core_pkg::ALU_SLL;
          3'b010: dec_d.alu_op = core_pkg::ALU_SLT;
          3'b011: dec_d.alu_op = core_pkg::ALU_SLTU;
          3'b100: dec_d.alu_op = core_pkg::ALU_XOR;
          3'b101: dec_d.alu_op = funct7[5] ? core_pkg::ALU_SRA : core_pkg::ALU_SRL;
          3'b110: dec_d.alu_op = core_pkg::ALU_OR;
          default: dec_d.alu_op = core_pkg::ALU_AND;
        endcase
        // 0100000 only for sub and sra
        if (funct7 == 7'b0100000) begin
          dec_d.illegal = (funct3 != 3'b000) && (funct3 != 3'b101);
        end else begin
          dec_d.illegal = (funct7 != 7'b0000000);
        end
      end
      core_pkg::OPC_OP_IMM: begin
        dec_d.we      = 1'b1;
        dec_d.use_imm = 1'b1;
        dec_d.imm     = imm_i;
        case (funct3)
          3'b000: dec_d.alu_op = core_pkg::ALU_ADD;
          3'b001: begin
            dec_d.alu_op  = core_pkg::ALU_SLL;
            dec_d.illegal = (funct7 != 7'b0000000);
          end
          3'b010: dec_d.alu_op = core_pkg::ALU_SLT;
          3'b011: dec_d.alu_op = core_pkg::ALU_SLTU;
          3'b100: dec_d.alu_op = core_pkg::ALU_XOR;
          3'b101: begin
            dec_d.alu_op  = funct7[5] ? core_pkg::ALU_SRA : core_pkg::ALU_SRL;
            dec_d.illegal = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
          end
          3'b110: dec_d.alu_op = core_pkg::ALU_OR;
          default: dec_d.alu_op = core_pkg::ALU_AND;
        endcase
      end
      core_pkg::OPC_LUI: begin
        // x0 as operand a gives imm + 0
        dec_d.we      = 1'b1;
        dec_d.use_imm = 1'b1;
        dec_d.rs1     = '0;
        dec_d.imm     = imm_u;
      end
      core_pkg::OPC_AUIPC: begin
        dec_d.we      = 1'b1;
        dec_d.use_imm = 1'b1;
        dec_d.use_pc  = 1'b1;
        dec_d.imm     = imm_u;
      end
      core_pkg::OPC_JAL: begin
        dec_d.we     = 1'b1;
        dec_d.is_jal = 1'b1;
        dec_d.imm    = imm_j;
      end
      core_pkg::OPC_JALR: begin
        dec_d.we      = 1'b1;
        dec_d.is_jalr = 1'b1;
        dec_d.imm     = imm_i;
        dec_d.illegal = (funct3 != 3'b000);
      end
      core_pkg::OPC_BRANCH: begin
        dec_d.is_branch = 1'b1;
        dec_d.imm       = imm_b;
        case (funct3)
          3'b000: dec_d.alu_op = core_pkg::ALU_EQ;
          3'b001: dec_d.alu_op = core_pkg::ALU_NE;
          3'b100: dec_d.alu_op = core_pkg::ALU_LT;
          3'b101: dec_d.alu_op = core_pkg::ALU_GE;
          3'b110: dec_d.alu_op = core_pkg::ALU_LTU;
          3'b111: dec_d.alu_op = core_pkg::ALU_GEU;
          default: dec_d.illegal = 1'b1;
        endcase
      end
      default: dec_d.illegal = 1'b1;
    endcase

    // an illegal encoding must not touch the register file
    if (dec_d.illegal) begin
      dec_d.we        = 1'b0;
      dec_d.is_branch = 1'b0;
      dec_d.is_jal    = 1'b0;
      dec_d.is_jalr   = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= instr_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    dec_q <= dec_d;
  end

  always_comb begin
    decoded_o       = dec_q;
    decoded_o.valid = valid_q;
  end

endmodule

`default_nettype wire

/* logic/regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module regfile (
  input  wire logic                              clk_i,
  input  wire logic                              rst_ni,
  input  wire logic [core_pkg::REG_ADDR_W-1:0]   rs1_addr_i,
  input  wire logic [core_pkg::REG_ADDR_W-1:0]   rs2_addr_i,
  output logic [core_pkg::XLEN-1:0]              rs1_data_o,
  output logic [core_pkg::XLEN-1:0]              rs2_data_o,
  input  core_pkg::reg_write_t                   write_i
);

  logic [core_pkg::XLEN-1:0] regs_q [core_pkg::NR_REGS];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < core_pkg::NR_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (write_i.en && (write_i.addr != '0)) begin
      regs_q[write_i.addr] <= write_i.data;
    end
  end

  // x0 is hard-wired
  assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs_q[rs1_addr_i];
  assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs_q[rs2_addr_i];

endmodule

`default_nettype wire

/* logic/core_pkg.sv */
`default_nettype none

package core_pkg;

  // ----------------------------------------
  // widths and constants
  // ----------------------------------------
  localparam int unsigned XLEN       = 32;
  localparam int unsigned REG_ADDR_W = 5;
  localparam int unsigned NR_REGS    = 32;
  localparam int unsigned INSTRET_W  = 32;

  // mcause value for an illegal instruction
  localparam logic [XLEN-1:0] ILLEGAL_INSTR_CAUSE = 32'd2;

  // ----------------------------------------
  // encodings
  // ----------------------------------------
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_BRANCH = 7'b1100011
  } opcode_e;

  // arithmetic ops first, then the branch compares
  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
    ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA,
    ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
  } alu_op_e;

  // ----------------------------------------
  // stage payloads
  // ----------------------------------------
  typedef struct packed {
    logic                  valid;
    logic [XLEN-1:0]       pc;
    logic [31:0]           instr;
    alu_op_e               alu_op;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       imm;
    logic                  use_imm;
    logic                  use_pc;
    logic                  we;
    logic                  is_branch;
    logic                  is_jal;
    logic                  is_jalr;
    logic                  illegal;
  } decoded_instr_t;

  typedef struct packed {
    logic                  valid;
    logic [XLEN-1:0]       pc;
    logic [31:0]           instr;
    logic [REG_ADDR_W-1:0] rd;
    logic                  we;
    logic [XLEN-1:0]       result;
    logic                  taken;
    logic [XLEN-1:0]       target;
    logic                  illegal;
  } exec_result_t;

  typedef struct packed {
    logic                  en;
    logic [REG_ADDR_W-1:0] addr;
    logic [XLEN-1:0]       data;
  } reg_write_t;

  // one retired instruction, as seen by a trace consumer
  typedef struct packed {
    logic [XLEN-1:0]       pc;
    logic [31:0]           instr;
    logic [REG_ADDR_W-1:0] rd;
    logic                  we;
    logic [XLEN-1:0]       wdata;
    logic                  taken;
    logic [XLEN-1:0]       target;
    logic                  ex_valid;
    logic [XLEN-1:0]       cause;
  } commit_record_t;

endpackage

`default_nettype wire
